// File: verification/mips_testdata.txt
# T name random_wait | I instruction | D address word | S address data (in store order)
# All values in hex, one entry per line
T alu_forward 0
I 20010005
I 20020003
I 00221820
I 00612022
I 00812824
I 00a33025
I 0086382a
I 3c081234
I 35085678
I 20000007
I ac030100
I ac040104
I ac050108
I ac06010c
I ac070110
I ac080114
I ac000118
I 08000011
S 00000100 00000008
S 00000104 00000003
S 00000108 00000001
S 0000010c 00000009
S 00000110 00000001
S 00000114 12345678
S 00000118 00000000
T load_use 0
I 8c010200
I 00211020
I 8c030204
I 00622020
I ac040208
I 8c050208
I ac05020c
I ac020210
I 08000008
D 00000200 00000011
D 00000204 00000022
S 00000208 00000044
S 0000020c 00000044
S 00000210 00000022
T branches 0
I 20010001
I 20020001
I 10220003
I ac010300
I ac010304
I ac010308
I ac02030c
I 14200003
I ac010310
I ac010314
I ac010318
I 10200003
I 20030055
I ac03031c
I 0800000e
S 0000030c 00000001
S 0000031c 00000055
T jump 0
I 20010009
I 08000003
I ac010380
I ac010384
I 08000004
S 00000384 00000009
T alu_forward_wait 1
I 20010005
I 20020003
I 00221820
I 00612022
I 00812824
I 00a33025
I 0086382a
I 3c081234
I 35085678
I 20000007
I ac030100
I ac040104
I ac050108
I ac06010c
I ac070110
I ac080114
I ac000118
I 08000011
S 00000100 00000008
S 00000104 00000003
S 00000108 00000001
S 0000010c 00000009
S 00000110 00000001
S 00000114 12345678
S 00000118 00000000

// File: mips_pipeline.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/pipe_ifs.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipeline.sv
verification/mips_pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mips_pipeline_tb
FLIST     ?= mips_pipeline.f
VFLAGS    ?= --binary --timing
SIM_ARGS  ?=

.PHONY: test clean help

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: verification/mips_pipeline_tb.sv
module mips_pipeline_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS = 16;
    localparam int MAX_WORDS = 1024;

    logic        ui_clk_from_ddr;
    logic        rst_n;
    logic        dmem_wait;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // Test table loaded from the data file
    string       test_name [MAX_TESTS];
    int          test_rand [MAX_TESTS];
    int          prog_base [MAX_TESTS];
    int          prog_len  [MAX_TESTS];
    int          data_base [MAX_TESTS];
    int          data_len  [MAX_TESTS];
    int          st_base   [MAX_TESTS];
    int          st_len    [MAX_TESTS];
    logic [31:0] prog_word [MAX_WORDS];
    logic [31:0] data_addr [MAX_WORDS];
    logic [31:0] data_word [MAX_WORDS];
    logic [31:0] st_addr   [MAX_WORDS];
    logic [31:0] st_data   [MAX_WORDS];
    int          num_tests;
    int          n_prog;
    int          n_data;
    int          n_st;

    int          cur_test;
    int          got;
    int          test_errs;
    int          cycles;
    int          limit_cycles;
    logic        running;
    logic        rand_wait;
    logic        loaded;
    logic [31:0] rng;

    mips_pipeline UUT (
        .ui_clk_from_ddr (ui_clk_from_ddr),
        .rst_n           (rst_n),
        .imem_rdata      (imem_rdata),
        .dmem_rdata      (dmem_rdata),
        .dmem_wait       (dmem_wait),
        .imem_addr       (imem_addr),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata),
        .dmem_we         (dmem_we),
        .dmem_re         (dmem_re)
    );

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    // Data word only while the read strobe is up
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : 32'hdead_beef;

    initial begin
        ui_clk_from_ddr = 1'b0;
        forever #5 ui_clk_from_ddr = ~ui_clk_from_ddr;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Data memory writes and store checking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            if ((dmem_we || dmem_re) && running) begin
                $display("Memory access seen while reset was asserted");
                test_errs = test_errs + 1;
            end
            cycles = 0;
        end else begin
            if (running && dmem_we && dmem_re) begin
                $display("Read and write strobes both high at %h", dmem_addr);
                test_errs = test_errs + 1;
            end
            if (running && dmem_re && cycles < 3) begin
                $display("Load seen before the pipeline was filled");
                test_errs = test_errs + 1;
            end
            if (dmem_we && !dmem_wait) begin
                dmem[dmem_addr[9:2]] = dmem_wdata;
                if (running) begin
                    // First instruction reaches memory on the fourth edge
                    if (cycles < 3) begin
                        $display("Store seen before the pipeline was filled");
                        test_errs = test_errs + 1;
                    end
                    if (got >= st_len[cur_test]) begin
                        $display("Unexpected extra store to %h", dmem_addr);
                        test_errs = test_errs + 1;
                    end else if (dmem_addr != st_addr[st_base[cur_test] + got] ||
                                 dmem_wdata != st_data[st_base[cur_test] + got]) begin
                        $display("ERR %0t: store %0d at %h data %h, expected %h data %h",
                                 $time, got, dmem_addr, dmem_wdata,
                                 st_addr[st_base[cur_test] + got],
                                 st_data[st_base[cur_test] + got]);
                        test_errs = test_errs + 1;
                    end
                    got = got + 1;
                end
            end
            cycles = cycles + 1;
        end
    end

    // One falling edge, with a new wait level
    task automatic step_cycle();
        @(negedge ui_clk_from_ddr);
        if (rand_wait) begin
            rng = next_random(rng);
            dmem_wait = rng[0] & rng[3];
        end else begin
            dmem_wait = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        @(negedge ui_clk_from_ddr);
        rst_n     = 1'b0;
        dmem_wait = 1'b0;
        running   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = 32'h0000_0000;
            dmem[i[7:0]] = 32'h5a5a_0000 ^ (i * 32'h0101_0101);
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i[7:0]] = prog_word[prog_base[t] + i];
        end
        for (int i = 0; i < data_len[t]; i++) begin
            dmem[data_addr[data_base[t] + i][9:2]] = data_word[data_base[t] + i];
        end
        cur_test  = t;
        got       = 0;
        test_errs = 0;
        rand_wait = (test_rand[t] != 0);
        running   = 1'b1;
        repeat (3) @(negedge ui_clk_from_ddr);
        rst_n = 1'b1;
        while (got < st_len[t]) begin
            step_cycle();
        end
        // Drain so that a late extra store is caught
        repeat (20) step_cycle();
        running = 1'b0;
    endtask

    task automatic load_tests();
        int          fd;
        int          flag;
        string       line;
        string       name;
        logic [31:0] a;
        logic [31:0] w;
        fd = $fopen("verification/mips_testdata.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            case (line.substr(0, 0))
                "T": begin
                    void'($sscanf(line, "T %s %d", name, flag));
                    test_name[num_tests] = name;
                    test_rand[num_tests] = flag;
                    prog_base[num_tests] = n_prog;
                    data_base[num_tests] = n_data;
                    st_base[num_tests]   = n_st;
                    num_tests = num_tests + 1;
                end
                "I": begin
                    void'($sscanf(line, "I %h", w));
                    prog_word[n_prog] = w;
                    n_prog = n_prog + 1;
                    prog_len[num_tests - 1] = prog_len[num_tests - 1] + 1;
                end
                "D": begin
                    void'($sscanf(line, "D %h %h", a, w));
                    data_addr[n_data] = a;
                    data_word[n_data] = w;
                    n_data = n_data + 1;
                    data_len[num_tests - 1] = data_len[num_tests - 1] + 1;
                end
                "S": begin
                    void'($sscanf(line, "S %h %h", a, w));
                    st_addr[n_st] = a;
                    st_data[n_st] = w;
                    n_st = n_st + 1;
                    st_len[num_tests - 1] = st_len[num_tests - 1] + 1;
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge ui_clk_from_ddr);
        $display("Run did not finish in %0d cycles", limit_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int passed;
        int failed;
        rst_n     = 1'b0;
        dmem_wait = 1'b0;
        running   = 1'b0;
        rand_wait = 1'b0;
        loaded    = 1'b0;
        rng       = 32'h5e9;
        cur_test  = 0;
        got       = 0;
        test_errs = 0;
        cycles    = 0;
        num_tests = 0;
        n_prog    = 0;
        n_data    = 0;
        n_st      = 0;
        passed    = 0;
        failed    = 0;
        for (int i = 0; i < MAX_TESTS; i++) begin
            prog_len[i] = 0;
            data_len[i] = 0;
            st_len[i]   = 0;
        end
        load_tests();
        limit_cycles = 0;
        for (int i = 0; i < num_tests; i++) begin
            limit_cycles = limit_cycles + 40 * prog_len[i] + 200;
        end
        loaded = 1'b1;
        if (num_tests == 0) begin
            $display("No tests could be read from the data file");
            failed = 1;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
            if (test_errs == 0) begin
                passed = passed + 1;
                $display("test %0d %s: pass, %0d stores", t, test_name[t], got);
            end else begin
                failed = failed + 1;
                $display("test %0d %s: fail, %0d errors", t, test_name[t], test_errs);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", num_tests, passed, failed);
        if (failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/mips_pipeline.sv
module mips_pipeline import mips_pkg::*; (
    input  logic  ui_clk_from_ddr,
    input  logic  rst_n,
    input  word_t imem_rdata,
    input  word_t dmem_rdata,
    input  logic  dmem_wait,
    output word_t imem_addr,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    output logic  dmem_re
);

    logic      ifid_valid;
    word_t     ifid_instr;
    word_t     ifid_pc_plus4;
    logic      hazard_stall;
    logic      jump;
    word_t     jump_pc;
    logic      redirect;
    word_t     redirect_pc;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    id_ex_bus  id_ex ();
    ex_mem_bus ex_mem ();

    fetch_stage u_fetch (
        .ui_clk_from_ddr (ui_clk_from_ddr),
        .rst_n           (rst_n),
        .dmem_wait       (dmem_wait),
        .hazard_stall    (hazard_stall),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .jump            (jump),
        .jump_pc         (jump_pc),
        .imem_rdata      (imem_rdata),
        .imem_addr       (imem_addr),
        .ifid_valid      (ifid_valid),
        .ifid_instr      (ifid_instr),
        .ifid_pc_plus4   (ifid_pc_plus4)
    );

    decode_stage u_decode (
        .ui_clk_from_ddr (ui_clk_from_ddr),
        .rst_n           (rst_n),
        .dmem_wait       (dmem_wait),
        .redirect        (redirect),
        .ifid_valid      (ifid_valid),
        .ifid_instr      (ifid_instr),
        .ifid_pc_plus4   (ifid_pc_plus4),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .hazard_stall    (hazard_stall),
        .jump            (jump),
        .jump_pc         (jump_pc),
        .id_ex           (id_ex)
    );

    execute_stage u_execute (
        .ui_clk_from_ddr (ui_clk_from_ddr),
        .rst_n           (rst_n),
        .dmem_wait       (dmem_wait),
        .redirect        (redirect),
        .id_ex           (id_ex),
        .ex_mem_fwd      (ex_mem),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .ex_mem          (ex_mem)
    );

    memory_stage u_memory (
        .ui_clk_from_ddr (ui_clk_from_ddr),
        .rst_n           (rst_n),
        .dmem_wait       (dmem_wait),
        .ex_mem          (ex_mem),
        .dmem_rdata      (dmem_rdata),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata),
        .dmem_we         (dmem_we),
        .dmem_re         (dmem_re),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

endmodule

// File: hdl/memory_stage.sv
module memory_stage import mips_pkg::*; (
    input  logic      ui_clk_from_ddr,
    input  logic      rst_n,
    input  logic      dmem_wait,
    ex_mem_bus.consumer ex_mem,
    input  word_t     dmem_rdata,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    output logic      dmem_re,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      wb_we,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    logic  taken;
    logic  wb_load;
    word_t wb_alu;
    word_t wb_mem;

    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.valid && ex_mem.mem_we;
    assign dmem_re    = ex_mem.valid && ex_mem.mem_re;

    // Zero flag comes from rs - rt
    always_comb begin
        case (ex_mem.br_cond)
            BR_EQ:   taken = ex_mem.zero;
            BR_NE:   taken = !ex_mem.zero;
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = ex_mem.valid && taken;
    assign redirect_pc = ex_mem.br_target;

    ////////////////////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr or negedge rst_n) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else if (!dmem_wait) begin
            wb_we <= ex_mem.valid && ex_mem.reg_we;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!dmem_wait) begin
            wb_rd   <= ex_mem.rd;
            wb_load <= ex_mem.mem_re;
            wb_alu  <= ex_mem.alu_result;
            wb_mem  <= dmem_rdata;
        end
    end

    assign wb_data = wb_load ? wb_mem : wb_alu;

endmodule

// File: hdl/execute_stage.sv
module execute_stage import mips_pkg::*; (
    input  logic      ui_clk_from_ddr,
    input  logic      rst_n,
    input  logic      dmem_wait,
    input  logic      redirect,
    id_ex_bus.consumer id_ex,
    ex_mem_bus.monitor ex_mem_fwd,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    ex_mem_bus.producer ex_mem
);

    logic      mem_fwd_ok;
    logic      wb_fwd_ok;
    reg_addr_t mem_rd;
    word_t     mem_result;
    fwd_sel_e  sel_a;
    fwd_sel_e  sel_b;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_b;
    word_t     alu_y;
    word_t     br_target;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////////////////////

    assign mem_fwd_ok = ex_mem_fwd.valid && ex_mem_fwd.reg_we && (ex_mem_fwd.rd != '0);
    assign mem_rd     = ex_mem_fwd.rd;
    assign mem_result = ex_mem_fwd.alu_result;
    assign wb_fwd_ok  = wb_we && (wb_rd != '0);

    // Younger producer in memory wins over writeback
    function automatic fwd_sel_e pick_src(input reg_addr_t src);
        fwd_sel_e sel;
        if (mem_fwd_ok && mem_rd == src) begin
            sel = FWD_MEM;
        end else if (wb_fwd_ok && wb_rd == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    function automatic word_t route(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        sel_a = pick_src(id_ex.rs);
        sel_b = pick_src(id_ex.rt);
        op_a  = route(sel_a, id_ex.rs_val);
        op_b  = route(sel_b, id_ex.rt_val);
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU and branch target
    ////////////////////////////////////////////////////////////////////////////

    assign alu_b = id_ex.b_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_y = op_a + alu_b;
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            ALU_SLT: alu_y = word_t'($signed(op_a) < $signed(alu_b));
            ALU_LUI: alu_y = {alu_b[15:0], 16'h0000};
            default: alu_y = '0;
        endcase
    end

    assign br_target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

    // EX/MEM register
    always_ff @(posedge ui_clk_from_ddr or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else if (!dmem_wait) begin
            ex_mem.valid <= id_ex.valid && !redirect;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!dmem_wait) begin
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= op_b;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_re     <= id_ex.mem_re;
            ex_mem.mem_we     <= id_ex.mem_we;
            ex_mem.reg_we     <= id_ex.reg_we;
            ex_mem.br_cond    <= id_ex.br_cond;
            ex_mem.zero       <= (alu_y == '0);
            ex_mem.br_target  <= br_target;
        end
    end

endmodule

// File: hdl/decode_stage.sv
`include "mips_settings.svh"

module decode_stage import mips_pkg::*; (
    input  logic      ui_clk_from_ddr,
    input  logic      rst_n,
    input  logic      dmem_wait,
    input  logic      redirect,
    input  logic      ifid_valid,
    input  word_t     ifid_instr,
    input  word_t     ifid_pc_plus4,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      hazard_stall,
    output logic      jump,
    output word_t     jump_pc,
    id_ex_bus.producer id_ex
);

    opcode_e      opcode;
    funct_e       funct;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    rd;
    logic [15:0]  imm;
    word_t        imm_ext;
    word_t        rs_val;
    word_t        rt_val;
    word_t        regs [`MIPS_REG_COUNT];

    alu_op_e      alu_op;
    branch_cond_e br_cond;
    logic         b_imm;
    logic         mem_re;
    logic         mem_we;
    logic         reg_we;
    logic         dst_rd;
    logic         zero_ext;
    logic         use_rs;
    logic         use_rt;
    logic         is_j;

    assign opcode = opcode_e'(ifid_instr[`MIPS_OP_HI:`MIPS_OP_LO]);
    assign funct  = funct_e'(ifid_instr[`MIPS_FUNCT_HI:`MIPS_FUNCT_LO]);
    assign rs     = ifid_instr[`MIPS_RS_HI:`MIPS_RS_LO];
    assign rt     = ifid_instr[`MIPS_RT_HI:`MIPS_RT_LO];
    assign rd     = ifid_instr[`MIPS_RD_HI:`MIPS_RD_LO];
    assign imm    = ifid_instr[`MIPS_IMM_HI:`MIPS_IMM_LO];

    assign imm_ext = zero_ext ? {{(`MIPS_DATA_WIDTH-16){1'b0}}, imm}
                              : {{(`MIPS_DATA_WIDTH-16){imm[15]}}, imm};

    ////////////////////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op   = ALU_ADD;
        br_cond  = BR_NONE;
        b_imm    = 1'b0;
        mem_re   = 1'b0;
        mem_we   = 1'b0;
        reg_we   = 1'b0;
        dst_rd   = 1'b0;
        zero_ext = 1'b0;
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        is_j     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dst_rd = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
                reg_we = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_we = 1'b0;
                endcase
            end
            OP_ADDI: begin
                b_imm  = 1'b1;
                reg_we = 1'b1;
                use_rs = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                b_imm    = 1'b1;
                zero_ext = 1'b1;
                reg_we   = 1'b1;
                use_rs   = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                b_imm  = 1'b1;
                reg_we = 1'b1;
            end
            OP_LW: begin
                b_imm  = 1'b1;
                mem_re = 1'b1;
                reg_we = 1'b1;
                use_rs = 1'b1;
            end
            OP_SW: begin
                b_imm  = 1'b1;
                mem_we = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                alu_op  = ALU_SUB;
                br_cond = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
                use_rs  = 1'b1;
                use_rt  = 1'b1;
            end
            OP_J:    is_j = 1'b1;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file, register zero reads as zero
    ////////////////////////////////////////////////////////////////////////////

    // A writeback in this very cycle is seen by the read
    function automatic word_t rf_read(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_we && wb_rd == addr) begin
            value = wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_val = rf_read(rs);
        rt_val = rf_read(rt);
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Load in EX feeding this instruction
    assign hazard_stall = ifid_valid && id_ex.valid && id_ex.mem_re &&
                          ((use_rs && id_ex.rd == rs) || (use_rt && id_ex.rd == rt));

    assign jump    = ifid_valid && is_j;
    assign jump_pc = {ifid_pc_plus4[31:28], ifid_instr[`MIPS_TARGET_HI:`MIPS_TARGET_LO], 2'b00};

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else if (!dmem_wait) begin
            id_ex.valid <= ifid_valid && !hazard_stall && !redirect;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!dmem_wait) begin
            id_ex.pc_plus4 <= ifid_pc_plus4;
            id_ex.rs_val   <= rs_val;
            id_ex.rt_val   <= rt_val;
            id_ex.rs       <= rs;
            id_ex.rt       <= rt;
            id_ex.rd       <= dst_rd ? rd : rt;
            id_ex.imm      <= imm_ext;
            id_ex.alu_op   <= alu_op;
            id_ex.b_imm    <= b_imm;
            id_ex.mem_re   <= mem_re;
            id_ex.mem_we   <= mem_we;
            id_ex.reg_we   <= reg_we;
            id_ex.br_cond  <= br_cond;
        end
    end

endmodule

// File: hdl/fetch_stage.sv
`include "mips_settings.svh"

module fetch_stage import mips_pkg::*; (
    input  logic  ui_clk_from_ddr,
    input  logic  rst_n,
    input  logic  dmem_wait,
    input  logic  hazard_stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  logic  jump,
    input  word_t jump_pc,
    input  word_t imem_rdata,
    output word_t imem_addr,
    output logic  ifid_valid,
    output word_t ifid_instr,
    output word_t ifid_pc_plus4
);

    word_t pc;
    word_t pc_plus4;
    word_t pc_next;

    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    // Branch redirect beats jump, jump beats the load-use hold
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (jump) begin
            pc_next = jump_pc;
        end else if (hazard_stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge ui_clk_from_ddr or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else if (!dmem_wait) begin
            pc <= pc_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr or negedge rst_n) begin
        if (!rst_n) begin
            ifid_valid <= 1'b0;
        end else if (!dmem_wait) begin
            if (redirect || jump) begin
                ifid_valid <= 1'b0;
            end else if (!hazard_stall) begin
                ifid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!dmem_wait && !hazard_stall) begin
            ifid_instr    <= imem_rdata;
            ifid_pc_plus4 <= pc_plus4;
        end
    end

endmodule

// File: hdl/pipe_ifs.sv
// Decode to execute
interface id_ex_bus import mips_pkg::*; ();

    logic         valid;
    word_t        pc_plus4;
    word_t        rs_val;
    word_t        rt_val;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    rd;
    word_t        imm;
    alu_op_e      alu_op;
    logic         b_imm;
    logic         mem_re;
    logic         mem_we;
    logic         reg_we;
    branch_cond_e br_cond;

    modport producer (
        output valid, pc_plus4, rs_val, rt_val, rs, rt, rd, imm,
        output alu_op, b_imm, mem_re, mem_we, reg_we, br_cond
    );

    modport consumer (
        input valid, pc_plus4, rs_val, rt_val, rs, rt, rd, imm,
        input alu_op, b_imm, mem_re, mem_we, reg_we, br_cond
    );

endinterface

// Execute to memory
interface ex_mem_bus import mips_pkg::*; ();

    logic         valid;
    word_t        alu_result;
    word_t        store_data;
    reg_addr_t    rd;
    logic         mem_re;
    logic         mem_we;
    logic         reg_we;
    branch_cond_e br_cond;
    logic         zero;
    word_t        br_target;

    modport producer (
        output valid, alu_result, store_data, rd, mem_re, mem_we, reg_we,
        output br_cond, zero, br_target
    );

    modport consumer (
        input valid, alu_result, store_data, rd, mem_re, mem_we, reg_we,
        input br_cond, zero, br_target
    );

    // Forwarding view
    modport monitor (input valid, alu_result, rd, reg_we);

endinterface

// File: hdl/mips_pkg.sv
`include "mips_settings.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_WIDTH-1:0] word_t;
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] reg_addr_t;

    // Primary opcode field
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // Funct field of R-type
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_cond_e;

    // Operand source in execute
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

// File: hdl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath size
`define MIPS_DATA_WIDTH 32
`define MIPS_REG_COUNT 32
`define MIPS_RESET_PC 32'h0000_0000

// Instruction field positions
`define MIPS_OP_HI 31
`define MIPS_OP_LO 26
`define MIPS_RS_HI 25
`define MIPS_RS_LO 21
`define MIPS_RT_HI 20
`define MIPS_RT_LO 16
`define MIPS_RD_HI 15
`define MIPS_RD_LO 11
`define MIPS_FUNCT_HI 5
`define MIPS_FUNCT_LO 0
`define MIPS_IMM_HI 15
`define MIPS_IMM_LO 0
`define MIPS_TARGET_HI 25
`define MIPS_TARGET_LO 0

`endif
